/* compile.f */
hdl/core_pkg.sv
hdl/fetch.sv
hdl/regs.sv
hdl/decoder.sv
hdl/execute.sv
hdl/riscv.sv
verification/tb_clock.sv
verification/imem_model.sv
verification/riscv_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = riscv_tb
FILELIST = compile.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verification/riscv_tb.sv */
`timescale 1ns/1ps

module riscv_tb;

    localparam core_pkg::addr_t RESET_PC = 32'h0;
    localparam int PROG_WORDS = 20;
    localparam core_pkg::addr_t LOOP_PC = 32'h4c;
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic rst;
    core_pkg::ibus_req_t ireq;
    core_pkg::ibus_resp_t iresp;
    core_pkg::addr_t pc;
    core_pkg::word_t [31:0] regs;
    logic valid;
    core_pkg::inst_t inst;
    core_pkg::addr_t inst_pc;
    logic reg_write_enable;
    core_pkg::reg_addr reg_dest_addr;
    core_pkg::word_t reg_write_data;
    core_pkg::inst_t [PROG_WORDS-1:0] rom;

    core_pkg::addr_t model_pc;
    core_pkg::word_t [31:0] model_regs;
    core_pkg::inst_t exp_inst;
    core_pkg::addr_t exp_next_pc;
    logic exp_write;
    core_pkg::reg_addr exp_rd;
    core_pkg::word_t exp_data;
    core_pkg::word_t rs1_val;
    core_pkg::word_t rs2_val;
    logic after_reset;
    logic req_waiting;
    core_pkg::addr_t req_addr_q;
    logic [1:0] loop_hits;
    int cycles;
    int idx;

    tb_clock u_clock (.clk(clk));

    imem_model #(.PROG_WORDS(PROG_WORDS)) u_imem (.*);

    riscv #(.RESET_PC(RESET_PC)) u_dut (.*);

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, expected);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic core_pkg::inst_t program_word(input core_pkg::addr_t addr);
        program_word = (addr < 32'(PROG_WORDS * 4)) ? rom[addr[6:2]] : '0;
    endfunction

    // ISA reference for the instruction at the model pc
    always_comb begin
        exp_inst = program_word(model_pc);
        rs1_val = model_regs[exp_inst[19:15]];
        rs2_val = model_regs[exp_inst[24:20]];
        exp_rd = exp_inst[11:7];
        exp_next_pc = model_pc + 32'd4;
        exp_write = 1'b0;
        exp_data = '0;
        case (exp_inst[6:0])
            7'b0110011: begin
                exp_write = 1'b1;
                case ({exp_inst[31:25], exp_inst[14:12]})
                    10'h000: exp_data = rs1_val + rs2_val;
                    10'h100: exp_data = rs1_val - rs2_val;
                    10'h007: exp_data = rs1_val & rs2_val;
                    10'h006: exp_data = rs1_val | rs2_val;
                    10'h004: exp_data = rs1_val ^ rs2_val;
                    default: exp_write = 1'b0;
                endcase
            end
            7'b0010011: begin
                exp_write = (exp_inst[14:12] == 3'b000);
                exp_data = rs1_val + {{20{exp_inst[31]}}, exp_inst[31:20]};
            end
            7'b0110111: begin
                exp_write = 1'b1;
                exp_data = {exp_inst[31:12], 12'b0};
            end
            7'b1100011: begin
                if (exp_inst[14:12] == 3'b000 && rs1_val == rs2_val) begin
                    exp_next_pc = model_pc + {{19{exp_inst[31]}}, exp_inst[31], exp_inst[7],
                                              exp_inst[30:25], exp_inst[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                exp_write = 1'b1;
                exp_data = model_pc + 32'd4;
                exp_next_pc = model_pc + {{11{exp_inst[31]}}, exp_inst[31], exp_inst[19:12],
                                          exp_inst[20], exp_inst[30:21], 1'b0};
            end
            default: begin
                exp_write = 1'b0;
            end
        endcase
        if (exp_rd == 5'd0) begin
            exp_write = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            model_pc <= RESET_PC;
            model_regs <= '0;
            after_reset <= 1'b1;
            req_waiting <= 1'b0;
            req_addr_q <= '0;
            loop_hits <= 2'd0;
        end else begin
            after_reset <= 1'b0;
            req_waiting <= ireq.valid && !iresp.data_ok;
            req_addr_q <= ireq.addr;
            if (valid) begin
                model_pc <= exp_next_pc;
                if (exp_write) begin
                    model_regs[exp_rd] <= exp_data;
                end
                if (inst_pc == LOOP_PC && loop_hits != 2'd3) begin
                    loop_hits <= loop_hits + 2'd1;
                end
            end
        end
    end

    reset_valid: assert property (@(posedge clk) (rst || after_reset) |-> !valid)
        else report_value("valid", 32'($sampled(valid)), 32'h0);
    reset_write: assert property (@(posedge clk) (rst || after_reset) |-> !reg_write_enable)
        else report_value("reg_write_enable", 32'($sampled(reg_write_enable)), 32'h0);
    reset_req: assert property (@(posedge clk) (rst || after_reset) |-> !ireq.valid)
        else report_value("ireq.valid", 32'($sampled(ireq.valid)), 32'h0);
    reset_pc: assert property (@(posedge clk) (rst || after_reset) |-> pc == RESET_PC)
        else report_value("pc", $sampled(pc), RESET_PC);
    commit_range: assert property (@(posedge clk) disable iff (rst)
        valid |-> inst_pc < 32'(PROG_WORDS * 4))
        else report_failure("an instruction committed from outside the program");
    commit_pc: assert property (@(posedge clk) disable iff (rst) valid |-> inst_pc == model_pc)
        else report_value("inst_pc", $sampled(inst_pc), $sampled(model_pc));
    commit_inst: assert property (@(posedge clk) disable iff (rst) valid |-> inst == exp_inst)
        else report_value("inst", $sampled(inst), $sampled(exp_inst));
    commit_write: assert property (@(posedge clk) disable iff (rst)
        valid |-> reg_write_enable == exp_write)
        else report_value("reg_write_enable", 32'($sampled(reg_write_enable)),
                          32'($sampled(exp_write)));
    commit_rd: assert property (@(posedge clk) disable iff (rst)
        valid && exp_write |-> reg_dest_addr == exp_rd)
        else report_value("reg_dest_addr", 32'($sampled(reg_dest_addr)), 32'($sampled(exp_rd)));
    commit_data: assert property (@(posedge clk) disable iff (rst)
        valid && exp_write |-> reg_write_data == exp_data)
        else report_value("reg_write_data", $sampled(reg_write_data), $sampled(exp_data));
    x0_write: assert property (@(posedge clk) reg_write_enable |-> reg_dest_addr != 5'd0)
        else report_value("reg_dest_addr", 32'($sampled(reg_dest_addr)), 32'h0);
    x0_value: assert property (@(posedge clk) regs[0] == 32'h0)
        else report_value("regs[0]", $sampled(regs[0]), 32'h0);
    addr_held: assert property (@(posedge clk) disable iff (rst)
        req_waiting |-> ireq.addr == req_addr_q)
        else report_value("ireq.addr", $sampled(ireq.addr), $sampled(req_addr_q));

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (loop_hits < 2'd2 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (loop_hits < 2'd2) begin
            report_failure("timeout: the final self-loop was not committed twice");
        end else begin
            for (idx = 0; idx < 32; idx++) begin
                final_regs: assert (regs[idx] == model_regs[idx])
                    else report_value($sformatf("regs[%0d]", idx), regs[idx], model_regs[idx]);
            end
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* verification/imem_model.sv */
`timescale 1ns/1ps

module imem_model #(
    parameter int PROG_WORDS = 20
) (
    input  logic                             clk,
    input  logic                             rst,
    input  core_pkg::ibus_req_t              ireq,
    output core_pkg::ibus_resp_t             iresp,
    output core_pkg::inst_t [PROG_WORDS-1:0] rom
);

    logic [31:0] lfsr = 32'h1ba5;
    logic busy = 1'b0;
    logic [1:0] wait_left = 2'd0;
    logic resp_ok = 1'b0;
    core_pkg::inst_t resp_data = '0;

    assign iresp.data_ok = resp_ok;
    assign iresp.data = resp_data;

    initial begin
        // addi x1 5, addi x2 -3, then the register ops
        rom[0] = 32'h00500093;
        rom[1] = 32'hffd00113;
        rom[2] = 32'h002081b3;
        rom[3] = 32'h40208233;
        rom[4] = 32'h0020f2b3;
        rom[5] = 32'h0020e333;
        rom[6] = 32'h0020c3b3;
        // lui x8, beq not taken, addi x9
        rom[7] = 32'h12345437;
        rom[8] = 32'h00208463;
        rom[9] = 32'h67840493;
        // beq taken over two words
        rom[10] = 32'h00108663;
        rom[11] = 32'h00100513;
        rom[12] = 32'h00200513;
        // jal x11 forward over two words
        rom[13] = 32'h00c005ef;
        rom[14] = 32'h00700613;
        rom[15] = 32'h00800613;
        // custom-0 opcode, must not write x31
        rom[16] = 32'h00500f8b;
        rom[17] = 32'h409586b3;
        rom[18] = 32'h00368733;
        // jal x0 to itself
        rom[19] = 32'h0000006f;
    end

    // galois step, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic core_pkg::inst_t word_at(input core_pkg::addr_t addr);
        if (addr < 32'(PROG_WORDS * 4)) begin
            word_at = rom[addr[6:2]];
        end else begin
            // only fetched past a jump and then dropped
            word_at = ~addr;
        end
    endfunction

    always @(negedge clk or posedge rst) begin
        if (rst) begin
            busy = 1'b0;
            wait_left = 2'd0;
            resp_ok <= 1'b0;
        end else begin
            resp_ok <= 1'b0;
            if (ireq.valid) begin
                if (!busy) begin
                    busy = 1'b1;
                    lfsr = lfsr_step(lfsr);
                    wait_left[0] = lfsr[0];
                    lfsr = lfsr_step(lfsr);
                    wait_left[1] = lfsr[0];
                end
                if (wait_left == 2'd0) begin
                    busy = 1'b0;
                    resp_ok <= 1'b1;
                    resp_data <= word_at(ireq.addr);
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // 20 ns period
    always #(HALF_PERIOD) clk = ~clk;

endmodule

/* hdl/riscv.sv */
`timescale 1ns/1ps

module riscv #(
    parameter core_pkg::addr_t RESET_PC = 32'h0
) (
    input  logic                   clk,
    input  logic                   rst,
    output core_pkg::ibus_req_t    ireq,
    input  core_pkg::ibus_resp_t   iresp,
    output core_pkg::addr_t        pc,
    output core_pkg::word_t [31:0] regs,
    output logic                   valid,
    output core_pkg::inst_t        inst,
    output core_pkg::addr_t        inst_pc,
    output logic                   reg_write_enable,
    output core_pkg::reg_addr      reg_dest_addr,
    output core_pkg::word_t        reg_write_data
);

    core_pkg::if_id if_id_state, if_id_state_new;
    core_pkg::id_ex id_ex_state;
    core_pkg::reg_writer writer;
    core_pkg::jump_writer jump;
    logic fetch_ok;

    fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .ireq(ireq),
        .iresp(iresp),
        .jump(jump),
        .pc(pc),
        .if_id_state(if_id_state_new),
        .ok(fetch_ok)
    );

    // stage register, a bubble when fetch has nothing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_id_state <= '0;
        end else begin
            if_id_state <= if_id_state_new;
            if_id_state.valid <= fetch_ok;
        end
    end

    decoder u_decoder (
        .if_id_state(if_id_state),
        .regs_value(regs),
        .id_ex_state(id_ex_state)
    );

    regs u_regs (
        .clk(clk),
        .rst(rst),
        .reg_write_enable(writer.reg_write_enable),
        .reg_dest_addr(writer.reg_dest_addr),
        .reg_write_data(writer.reg_write_data),
        .regs_value(regs)
    );

    execute u_execute (
        .id_ex_state(id_ex_state),
        .writer(writer),
        .jump(jump)
    );

    // commit view of the instruction in the second stage
    assign valid = id_ex_state.valid;
    assign inst = id_ex_state.inst;
    assign inst_pc = id_ex_state.pc;
    assign reg_write_enable = writer.reg_write_enable;
    assign reg_dest_addr = writer.reg_dest_addr;
    assign reg_write_data = writer.reg_write_data;

    // a commit follows its data_ok by one cycle
    commit_after_resp: assert property (@(posedge clk) disable iff (rst)
        valid |-> $past(iresp.data_ok));

endmodule

/* hdl/execute.sv */
`timescale 1ns/1ps

module execute (
    input  core_pkg::id_ex       id_ex_state,
    output core_pkg::reg_writer  writer,
    output core_pkg::jump_writer jump
);

    core_pkg::word_t alu_result;
    core_pkg::word_t link_addr;
    logic branch_taken;

    always_comb begin
        case (id_ex_state.op)
            core_pkg::add: alu_result = id_ex_state.operand_a + id_ex_state.operand_b;
            core_pkg::sub: alu_result = id_ex_state.operand_a - id_ex_state.operand_b;
            core_pkg::and_op: alu_result = id_ex_state.operand_a & id_ex_state.operand_b;
            core_pkg::or_op: alu_result = id_ex_state.operand_a | id_ex_state.operand_b;
            core_pkg::xor_op: alu_result = id_ex_state.operand_a ^ id_ex_state.operand_b;
            core_pkg::pass_b: alu_result = id_ex_state.operand_b;
            default: alu_result = '0;
        endcase
    end

    assign link_addr = id_ex_state.pc + 32'd4;

    // beq compares rs1 against rs2
    assign branch_taken = id_ex_state.is_branch
                          && (id_ex_state.operand_a == id_ex_state.rs2_value);

    always_comb begin
        writer.reg_write_enable = id_ex_state.valid && id_ex_state.write_en
                                  && (id_ex_state.rd != 5'd0);
        writer.reg_dest_addr = id_ex_state.rd;
        writer.reg_write_data = id_ex_state.is_jal ? link_addr : alu_result;
    end

    always_comb begin
        jump.valid = id_ex_state.valid && (id_ex_state.is_jal || branch_taken);
        jump.target = id_ex_state.pc + id_ex_state.imm;
    end

endmodule

/* hdl/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  core_pkg::if_id         if_id_state,
    input  core_pkg::word_t [31:0] regs_value,
    output core_pkg::id_ex         id_ex_state
);

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;

    core_pkg::inst_t inst;
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    core_pkg::reg_addr rs1, rs2;
    core_pkg::word_t imm_i, imm_u, imm_b, imm_j;

    assign inst = if_id_state.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        id_ex_state.valid = if_id_state.valid;
        id_ex_state.pc = if_id_state.pc;
        id_ex_state.inst = inst;
        id_ex_state.op = core_pkg::none;
        id_ex_state.operand_a = regs_value[rs1];
        id_ex_state.rs2_value = regs_value[rs2];
        id_ex_state.operand_b = regs_value[rs2];
        id_ex_state.imm = '0;
        id_ex_state.rd = inst[11:7];
        id_ex_state.write_en = 1'b0;
        id_ex_state.is_branch = 1'b0;
        id_ex_state.is_jal = 1'b0;
        case (opcode)
            OP_REG: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: id_ex_state.op = core_pkg::add;
                        3'b111: id_ex_state.op = core_pkg::and_op;
                        3'b110: id_ex_state.op = core_pkg::or_op;
                        3'b100: id_ex_state.op = core_pkg::xor_op;
                        default: id_ex_state.op = core_pkg::none;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    id_ex_state.op = core_pkg::sub;
                end
                id_ex_state.write_en = (id_ex_state.op != core_pkg::none);
            end
            OP_IMM: begin
                // only addi
                if (funct3 == 3'b000) begin
                    id_ex_state.op = core_pkg::add;
                    id_ex_state.operand_b = imm_i;
                    id_ex_state.imm = imm_i;
                    id_ex_state.write_en = 1'b1;
                end
            end
            OP_LUI: begin
                id_ex_state.op = core_pkg::pass_b;
                id_ex_state.operand_b = imm_u;
                id_ex_state.imm = imm_u;
                id_ex_state.write_en = 1'b1;
            end
            OP_BRANCH: begin
                if (funct3 == 3'b000) begin
                    id_ex_state.is_branch = 1'b1;
                    id_ex_state.imm = imm_b;
                end
            end
            OP_JAL: begin
                id_ex_state.is_jal = 1'b1;
                id_ex_state.imm = imm_j;
                id_ex_state.write_en = 1'b1;
            end
            default: begin
                id_ex_state.op = core_pkg::none;
            end
        endcase
    end

endmodule

/* hdl/regs.sv */
`timescale 1ns/1ps

module regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   reg_write_enable,
    input  core_pkg::reg_addr      reg_dest_addr,
    input  core_pkg::word_t        reg_write_data,
    output core_pkg::word_t [31:0] regs_value
);

    core_pkg::word_t [31:0] mem;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem <= '0;
        end else if (reg_write_enable && reg_dest_addr != 5'd0) begin
            // x0 is never written
            mem[reg_dest_addr] <= reg_write_data;
        end
    end

    assign regs_value = mem;

    x0_zero: assert property (@(posedge clk) regs_value[0] == 32'h0);

endmodule

/* hdl/fetch.sv */
`timescale 1ns/1ps

module fetch #(
    parameter core_pkg::addr_t RESET_PC = 32'h0
) (
    input  logic                 clk,
    input  logic                 rst,
    output core_pkg::ibus_req_t  ireq,
    input  core_pkg::ibus_resp_t iresp,
    input  core_pkg::jump_writer jump,
    output core_pkg::addr_t      pc,
    output core_pkg::if_id       if_id_state,
    output logic                 ok
);

    core_pkg::fetch_state_e state, state_next;
    core_pkg::addr_t pc_q, pc_next;
    core_pkg::addr_t target_q, target_next;

    assign ireq.valid = (state == core_pkg::wait_resp) || (state == core_pkg::drop);
    assign ireq.addr = pc_q;
    assign pc = pc_q;

    // word is kept only when no redirect is under way
    assign ok = (state == core_pkg::wait_resp) && iresp.data_ok && !jump.valid;

    assign if_id_state.valid = ok;
    assign if_id_state.pc = pc_q;
    assign if_id_state.inst = iresp.data;

    always_comb begin
        state_next = state;
        pc_next = pc_q;
        target_next = target_q;
        case (state)
            core_pkg::idle: begin
                state_next = core_pkg::wait_resp;
            end
            core_pkg::wait_resp: begin
                if (iresp.data_ok) begin
                    pc_next = jump.valid ? jump.target : pc_q + 32'd4;
                end else if (jump.valid) begin
                    // request still in flight, its word gets thrown away
                    state_next = core_pkg::drop;
                    target_next = jump.target;
                end
            end
            core_pkg::drop: begin
                if (iresp.data_ok) begin
                    state_next = core_pkg::wait_resp;
                    pc_next = target_q;
                end
            end
            default: begin
                state_next = core_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= core_pkg::idle;
            pc_q <= RESET_PC;
            target_q <= '0;
        end else begin
            state <= state_next;
            pc_q <= pc_next;
            target_q <= target_next;
        end
    end

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        ireq.valid && !iresp.data_ok |=> $stable(ireq.addr));

    resp_outstanding: assert property (@(posedge clk) disable iff (rst)
        iresp.data_ok |-> (state == core_pkg::wait_resp || state == core_pkg::drop));

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0] reg_addr;

    // instruction bus, request held until data_ok
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic  data_ok;
        inst_t data;
    } ibus_resp_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } if_id;

    typedef enum logic [2:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        pass_b,
        none
    } alu_op_e;

    typedef struct packed {
        logic    valid;
        addr_t   pc;
        inst_t   inst;
        alu_op_e op;
        word_t   operand_a;
        word_t   operand_b;
        word_t   rs2_value;
        word_t   imm;
        reg_addr rd;
        logic    write_en;
        logic    is_branch;
        logic    is_jal;
    } id_ex;

    typedef struct packed {
        logic    reg_write_enable;
        reg_addr reg_dest_addr;
        word_t   reg_write_data;
    } reg_writer;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } jump_writer;

    typedef enum logic [1:0] {
        idle,
        wait_resp,
        drop
    } fetch_state_e;

endpackage
